/* all.f */
hw/pdh_pkg.sv
hw/coef_if.sv
hw/gpio_cmd_sync.sv
hw/config_regs.sv
hw/adc_front.sv
hw/rot_lane.sv
hw/dma_sequencer.sv
hw/readback_mux.sv
hw/dac_driver.sv
hw/pdh_core.sv
tests/tb_pdh_core.sv

/* hw/adc_front.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_front (
    input  wire                                  clk,
    input  wire                                  rst_i,
    input  wire        [pdh_pkg::ADC_W-1:0]      adc_a_i,
    input  wire        [pdh_pkg::ADC_W-1:0]      adc_b_i,
    coef_if.sink                                 coef,
    output logic signed [pdh_pkg::COEF_W-1:0]    a_s_o,
    output logic signed [pdh_pkg::COEF_W-1:0]    b_s_o,
    output logic signed [pdh_pkg::COEF_W-1:0]    lane_c0_o [pdh_pkg::NUM_LANES],
    output logic signed [pdh_pkg::COEF_W-1:0]    lane_c1_o [pdh_pkg::NUM_LANES],
    output logic signed [pdh_pkg::COEF_W-1:0]    lane_x0_o [pdh_pkg::NUM_LANES],
    output logic signed [pdh_pkg::COEF_W-1:0]    lane_x1_o [pdh_pkg::NUM_LANES]
);
    import pdh_pkg::*;

    localparam int PAD_W = COEF_W - ADC_W;

    // Offset binary to signed, sense inverted
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            a_s_o <= '0;
            b_s_o <= '0;
        end else begin
            a_s_o <= ADC_OFFSET - $signed({{PAD_W{1'b0}}, adc_a_i});
            b_s_o <= ADC_OFFSET - $signed({{PAD_W{1'b0}}, adc_b_i});
        end
    end

    ////////////////////////////////////////
    // Lane 0 gives I, lane 1 gives Q
    assign lane_c0_o[0] = coef.cos_rot;
    assign lane_c1_o[0] = coef.sin_rot;
    assign lane_x0_o[0] = a_s_o;
    assign lane_x1_o[0] = b_s_o;

    assign lane_c0_o[1] = coef.cos_rot;
    assign lane_c1_o[1] = coef.sin_rot;
    assign lane_x0_o[1] = b_s_o;
    assign lane_x1_o[1] = -a_s_o;   // Turns the subtract into sin*a

endmodule

`default_nettype wire

/* hw/coef_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface coef_if;
    import pdh_pkg::*;

    logic signed [COEF_W-1:0] cos_stage;
    logic signed [COEF_W-1:0] sin_stage;
    logic signed [COEF_W-1:0] cos_rot;   // Committed, used by the lanes
    logic signed [COEF_W-1:0] sin_rot;

    modport source (output cos_stage, sin_stage, cos_rot, sin_rot);
    modport sink (input cos_stage, sin_stage, cos_rot, sin_rot);

endinterface

`default_nettype wire

/* hw/config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module config_regs (
    input  wire                                clk,
    input  wire                                rst_i,
    input  wire pdh_pkg::cmd_word_t            cmd_word_i,
    coef_if.source                             coef,
    output logic [7:0]                         led_o,
    output logic [pdh_pkg::DAC_W-1:0]          dac1_o,
    output logic [pdh_pkg::DAC_W-1:0]          dac2_o,
    output logic [pdh_pkg::DEC_CODE_W-1:0]     dec_code_o
);
    import pdh_pkg::*;

    localparam int DAC_SEL_BIT = 14;
    localparam int SIN_SEL_BIT = 16;

    cmd_t              cmd;
    logic [DATA_W-1:0] data;

    assign cmd  = cmd_word_i.cmd;
    assign data = cmd_word_i.data;

    // Latched command rewrites the same value every cycle
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            led_o          <= '0;
            dac1_o         <= DAC_MID;
            dac2_o         <= DAC_MID;
            coef.cos_stage <= COEF_ONE;
            coef.sin_stage <= '0;
            coef.cos_rot   <= COEF_ONE;
            coef.sin_rot   <= '0;
            dec_code_o     <= DEC_CODE_RST;
        end else begin
            case (cmd)
                CMD_SET_LED: begin
                    led_o <= data[7:0];
                end
                CMD_SET_DAC: begin
                    if (data[DAC_SEL_BIT]) begin
                        dac2_o <= data[DAC_W-1:0];
                    end else begin
                        dac1_o <= data[DAC_W-1:0];
                    end
                end
                CMD_SET_ROT_COEFFS: begin
                    if (data[SIN_SEL_BIT]) begin
                        coef.sin_stage <= data[COEF_W-1:0];
                    end else begin
                        coef.cos_stage <= data[COEF_W-1:0];
                    end
                end
                CMD_COMMIT_ROT_COEFFS: begin   // Both angles switch together
                    coef.cos_rot <= coef.cos_stage;
                    coef.sin_rot <= coef.sin_stage;
                end
                CMD_GET_FRAME: begin
                    dec_code_o <= data[DEC_CODE_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    a_rot_on_commit: assert property (@(posedge clk) disable iff (rst_i)
        (!$stable(coef.cos_rot) || !$stable(coef.sin_rot))
            |-> $past(cmd) == CMD_COMMIT_ROT_COEFFS);

endmodule

`default_nettype wire

/* hw/dac_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module dac_driver (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire  [pdh_pkg::DAC_W-1:0]    dac1_i,
    input  wire  [pdh_pkg::DAC_W-1:0]    dac2_i,
    output logic [pdh_pkg::DAC_W-1:0]    dac_dat_o,
    output logic                         dac_sel_o,
    output logic                         dac_wrt_o,
    output logic                         dac_rst_o
);
    import pdh_pkg::*;

    logic [DAC_W-1:0] dac1_r;
    logic [DAC_W-1:0] dac2_r;

    // Falling edge keeps data away from the write strobe
    always_ff @(negedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac1_r    <= DAC_MID;
            dac2_r    <= DAC_MID;
            dac_sel_o <= 1'b0;
        end else begin
            dac1_r    <= dac1_i;
            dac2_r    <= dac2_i;
            dac_sel_o <= ~dac_sel_o;
        end
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac_rst_o <= 1'b1;
        end else begin
            dac_rst_o <= 1'b0;
        end
    end

    assign dac_wrt_o = clk;
    assign dac_dat_o = dac_sel_o ? dac2_r : dac1_r;

endmodule

`default_nettype wire

/* hw/dma_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_sequencer #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire pdh_pkg::cmd_word_t    cmd_word_i,
    input  wire                        dma_ready_i,
    input  wire                        bram_ready_i,
    output logic                       dma_ready_sync_o,
    output logic                       dma_enable_o,
    output logic                       bram_enable_o
);
    import pdh_pkg::*;

    logic [SYNC_STAGES-1:0] dma_sync_r;
    logic                   dma_ready_d_r;
    logic                   bram_ready_r;
    logic                   bram_ready_d_r;
    logic                   bram_acq_r;   // BRAM edge seen in RUN_BRAM
    logic                   dma_edge;
    logic                   bram_edge;
    logic                   get_frame;
    dma_state_t             state_r;
    dma_state_t             state_nxt;

    assign dma_ready_sync_o = dma_sync_r[SYNC_STAGES-1];
    assign dma_edge  = dma_ready_sync_o & ~dma_ready_d_r;
    assign bram_edge = bram_ready_r & ~bram_ready_d_r;
    assign get_frame = (cmd_word_i.cmd == CMD_GET_FRAME);

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            DMA_ARMED:    if (bram_ready_r && get_frame) state_nxt = DMA_RUN_BRAM;
            DMA_RUN_BRAM: if (bram_acq_r && dma_ready_sync_o) state_nxt = DMA_RUN_AXI;
            DMA_RUN_AXI:  if (dma_edge) state_nxt = DMA_STALE;
            DMA_STALE:    if (!get_frame) state_nxt = DMA_ARMED;   // Wait for command change
            default:      state_nxt = DMA_ARMED;
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dma_sync_r     <= '0;
            dma_ready_d_r  <= 1'b0;
            bram_ready_r   <= 1'b0;
            bram_ready_d_r <= 1'b0;
            bram_acq_r     <= 1'b0;
            state_r        <= DMA_ARMED;
            dma_enable_o   <= 1'b0;
            bram_enable_o  <= 1'b0;
        end else begin
            dma_sync_r     <= (dma_sync_r << 1) | SYNC_STAGES'(dma_ready_i);
            dma_ready_d_r  <= dma_ready_sync_o;
            bram_ready_r   <= bram_ready_i;
            bram_ready_d_r <= bram_ready_r;
            bram_acq_r     <= (state_r == DMA_RUN_BRAM) && (bram_acq_r || bram_edge);
            state_r        <= state_nxt;
            dma_enable_o   <= (state_r == DMA_RUN_AXI);
            bram_enable_o  <= (state_r == DMA_RUN_BRAM);
        end
    end

    a_enables_exclusive: assert property (@(posedge clk) disable iff (rst_i)
        !(dma_enable_o && bram_enable_o));

endmodule

`default_nettype wire

/* hw/gpio_cmd_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_cmd_sync #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire  [pdh_pkg::GPIO_W-1:0]   gpio_i,
    output pdh_pkg::cmd_word_t           cmd_word_o
);
    import pdh_pkg::*;

    localparam int STROBE_BIT = 30;

    logic [SYNC_STAGES-1:0][GPIO_W-1:0] sync_r;
    logic                               strobe_d_r;
    logic                               strobe_edge;
    logic [GPIO_W-1:0]                  gpio_sync;

    assign gpio_sync   = sync_r[SYNC_STAGES-1];
    assign strobe_edge = gpio_sync[STROBE_BIT] & ~strobe_d_r;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            sync_r     <= '0;
            strobe_d_r <= 1'b0;
            cmd_word_o <= '0;
        end else begin
            sync_r[0] <= gpio_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_r[i] <= sync_r[i-1];
            end
            strobe_d_r <= gpio_sync[STROBE_BIT];
            if (strobe_edge) begin
                cmd_word_o <= cmd_word_t'(gpio_sync[$bits(cmd_word_t)-1:0]);   // Held until next edge
            end
        end
    end

    // Command register only moves on a strobe edge
    a_cmd_on_edge: assert property (@(posedge clk) disable iff (rst_i)
        !$stable(cmd_word_o) |-> $past(strobe_edge));

endmodule

`default_nettype wire

/* hw/pdh_core.sv */
`timescale 1ns/100ps
`default_nettype none

module pdh_core #(
    parameter int ADC_DATA_WIDTH = pdh_pkg::ADC_W,
    parameter int DAC_DATA_WIDTH = pdh_pkg::DAC_W,
    parameter int SYNC_STAGES    = 3
) (
    input  wire                                 clk,
    input  wire                                 rst_i,
    input  wire  [ADC_DATA_WIDTH-1:0]           adc_dat_a_i,
    input  wire  [ADC_DATA_WIDTH-1:0]           adc_dat_b_i,
    output logic                                adc_csn_o,
    output logic [DAC_DATA_WIDTH-1:0]           dac_dat_o,
    output logic                                dac_wrt_o,
    output logic                                dac_rst_o,
    output logic                                dac_sel_o,
    input  wire  [pdh_pkg::GPIO_W-1:0]          axi_from_ps_i,
    output logic [pdh_pkg::GPIO_W-1:0]          axi_to_ps_o,
    output logic [7:0]                          led_o,
    output logic                                dma_enable_o,
    output logic                                bram_enable_o,
    input  wire                                 dma_ready_i,
    input  wire                                 bram_ready_i,
    output logic [pdh_pkg::DEC_CODE_W-1:0]      dma_decimation_code_o,
    output logic [4*pdh_pkg::COEF_W-1:0]        dma_data_o
);
    import pdh_pkg::*;

    cmd_word_t                cmd_word;
    logic [DAC_W-1:0]         dac1;
    logic [DAC_W-1:0]         dac2;
    logic signed [COEF_W-1:0] a_s;
    logic signed [COEF_W-1:0] b_s;
    logic signed [COEF_W-1:0] lane_c0 [NUM_LANES];
    logic signed [COEF_W-1:0] lane_c1 [NUM_LANES];
    logic signed [COEF_W-1:0] lane_x0 [NUM_LANES];
    logic signed [COEF_W-1:0] lane_x1 [NUM_LANES];
    logic signed [COEF_W-1:0] feed [NUM_LANES];   // I, Q
    logic                     dma_ready_sync;

    coef_if coef ();

    assign adc_csn_o = 1'b1;

    ////////////////////////////////////////
    // Command path
    gpio_cmd_sync #(.SYNC_STAGES(SYNC_STAGES)) gpio_cmd_sync_inst (
        .clk(clk), .rst_i(rst_i), .gpio_i(axi_from_ps_i), .cmd_word_o(cmd_word)
    );

    config_regs config_regs_inst (
        .clk(clk), .rst_i(rst_i), .cmd_word_i(cmd_word), .coef(coef.source),
        .led_o(led_o), .dac1_o(dac1), .dac2_o(dac2), .dec_code_o(dma_decimation_code_o)
    );

    ////////////////////////////////////////
    // Demodulation
    adc_front adc_front_inst (
        .clk(clk), .rst_i(rst_i), .adc_a_i(adc_dat_a_i), .adc_b_i(adc_dat_b_i),
        .coef(coef.sink), .a_s_o(a_s), .b_s_o(b_s),
        .lane_c0_o(lane_c0), .lane_c1_o(lane_c1), .lane_x0_o(lane_x0), .lane_x1_o(lane_x1)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        rot_lane rot_lane_inst (
            .clk(clk), .rst_i(rst_i),
            .c0_i(lane_c0[g]), .c1_i(lane_c1[g]), .x0_i(lane_x0[g]), .x1_i(lane_x1[g]),
            .y_o(feed[g])
        );
    end

    ////////////////////////////////////////
    // Capture, readback and DAC
    dma_sequencer #(.SYNC_STAGES(SYNC_STAGES)) dma_sequencer_inst (
        .clk(clk), .rst_i(rst_i), .cmd_word_i(cmd_word),
        .dma_ready_i(dma_ready_i), .bram_ready_i(bram_ready_i),
        .dma_ready_sync_o(dma_ready_sync),
        .dma_enable_o(dma_enable_o), .bram_enable_o(bram_enable_o)
    );

    readback_mux readback_mux_inst (
        .clk(clk), .rst_i(rst_i), .cmd_word_i(cmd_word), .coef(coef.sink),
        .led_i(led_o), .dac1_i(dac1), .dac2_i(dac2),
        .adc_a_i(adc_dat_a_i), .adc_b_i(adc_dat_b_i), .a_s_i(a_s), .b_s_i(b_s),
        .feed_i(feed), .dma_ready_sync_i(dma_ready_sync), .dec_code_i(dma_decimation_code_o),
        .callback_o(axi_to_ps_o), .dma_data_o(dma_data_o)
    );

    dac_driver dac_driver_inst (
        .clk(clk), .rst_i(rst_i), .dac1_i(dac1), .dac2_i(dac2),
        .dac_dat_o(dac_dat_o), .dac_sel_o(dac_sel_o),
        .dac_wrt_o(dac_wrt_o), .dac_rst_o(dac_rst_o)
    );

endmodule

`default_nettype wire

/* hw/pdh_pkg.sv */
`default_nettype none

package pdh_pkg;

    ////////////////////////////////////////
    // Widths
    localparam int ADC_W      = 14;
    localparam int DAC_W      = 14;
    localparam int GPIO_W     = 32;
    localparam int COEF_W     = 16;
    localparam int DEC_CODE_W = 22;
    localparam int CMD_W      = 4;
    localparam int DATA_W     = 26;
    localparam int NUM_LANES  = 2;   // I and Q

    ////////////////////////////////////////
    // Reset and conversion constants
    localparam logic signed [COEF_W-1:0] ADC_OFFSET   = 16'sd8192;   // Offset-binary midpoint
    localparam logic signed [COEF_W-1:0] COEF_ONE     = 16'sh7FFF;
    localparam logic [DAC_W-1:0]         DAC_MID      = 14'h2000;
    localparam logic [DEC_CODE_W-1:0]    DEC_CODE_RST = 22'd1;

    ////////////////////////////////////////
    // Command set
    typedef enum logic [CMD_W-1:0] {
        CMD_IDLE              = 4'd0,
        CMD_SET_LED           = 4'd1,
        CMD_SET_DAC           = 4'd2,
        CMD_GET_ADC           = 4'd3,
        CMD_CHECK_SIGNED      = 4'd4,
        CMD_SET_ROT_COEFFS    = 4'd5,
        CMD_COMMIT_ROT_COEFFS = 4'd6,
        CMD_GET_FRAME         = 4'd7
    } cmd_t;

    // Matches GPIO bits 29..0
    typedef struct packed {
        cmd_t              cmd;
        logic [DATA_W-1:0] data;
    } cmd_word_t;

    typedef enum logic [1:0] {
        DMA_ARMED    = 2'b00,
        DMA_RUN_BRAM = 2'b01,
        DMA_RUN_AXI  = 2'b10,
        DMA_STALE    = 2'b11
    } dma_state_t;

endpackage

`default_nettype wire

/* hw/readback_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module readback_mux (
    input  wire                                   clk,
    input  wire                                   rst_i,
    input  wire pdh_pkg::cmd_word_t               cmd_word_i,
    coef_if.sink                                  coef,
    input  wire        [7:0]                      led_i,
    input  wire        [pdh_pkg::DAC_W-1:0]       dac1_i,
    input  wire        [pdh_pkg::DAC_W-1:0]       dac2_i,
    input  wire        [pdh_pkg::ADC_W-1:0]       adc_a_i,
    input  wire        [pdh_pkg::ADC_W-1:0]       adc_b_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]      a_s_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]      b_s_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]      feed_i [pdh_pkg::NUM_LANES],
    input  wire                                   dma_ready_sync_i,
    input  wire        [pdh_pkg::DEC_CODE_W-1:0]  dec_code_i,
    output logic       [pdh_pkg::GPIO_W-1:0]      callback_o,
    output logic       [4*pdh_pkg::COEF_W-1:0]    dma_data_o
);
    import pdh_pkg::*;

    cmd_t                     cmd;
    logic [4:0]               sel;
    logic signed [COEF_W-1:0] i_val;
    logic signed [COEF_W-1:0] q_val;
    logic [COEF_W-1:0]        signed_val;
    logic [GPIO_W-1:0]        callback_nxt;

    assign cmd   = cmd_word_i.cmd;
    assign sel   = cmd_word_i.data[4:0];
    assign i_val = feed_i[0];
    assign q_val = feed_i[1];

    // CHECK_SIGNED selector
    always_comb begin
        case (sel)
            5'd0:    signed_val = a_s_i;
            5'd1:    signed_val = b_s_i;
            5'd2:    signed_val = coef.cos_stage;
            5'd3:    signed_val = coef.sin_stage;
            5'd4:    signed_val = coef.cos_rot;
            5'd5:    signed_val = coef.sin_rot;
            5'd6:    signed_val = i_val;
            5'd7:    signed_val = q_val;
            5'd8:    signed_val = {{(COEF_W-1){1'b0}}, dma_ready_sync_i};
            default: signed_val = '0;
        endcase
    end

    always_comb begin
        case (cmd)
            CMD_SET_LED:           callback_nxt = {cmd, 20'd0, led_i};
            CMD_SET_DAC:           callback_nxt = {cmd, dac1_i, dac2_i};
            CMD_GET_ADC:           callback_nxt = {cmd, adc_b_i, adc_a_i};
            CMD_CHECK_SIGNED:      callback_nxt = {cmd, 7'd0, sel, signed_val};
            CMD_SET_ROT_COEFFS:    callback_nxt = {cmd, coef.sin_stage[15:2], coef.cos_stage[15:2]};
            CMD_COMMIT_ROT_COEFFS: callback_nxt = {cmd, q_val[15:2], i_val[15:2]};
            CMD_GET_FRAME:         callback_nxt = {cmd, 5'd0, dec_code_i, dma_ready_sync_i};
            default:               callback_nxt = '0;   // IDLE and unknown codes
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            callback_o <= '0;
        end else begin
            callback_o <= callback_nxt;
        end
    end

    assign dma_data_o = {i_val, q_val, coef.cos_stage, coef.sin_stage};   // Fixed frame layout

endmodule

`default_nettype wire

/* hw/rot_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module rot_lane (
    input  wire                                  clk,
    input  wire                                  rst_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]     c0_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]     c1_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]     x0_i,
    input  wire signed [pdh_pkg::COEF_W-1:0]     x1_i,
    output logic signed [pdh_pkg::COEF_W-1:0]    y_o
);
    import pdh_pkg::*;

    localparam int PROD_W = 2 * COEF_W;

    logic signed [PROD_W:0]   diff;
    logic signed [PROD_W-1:0] sat;
    logic signed [PROD_W-1:0] scaled;

    assign diff = c0_i * x0_i - c1_i * x1_i;   // 33 bits, no wrap

    always_comb begin
        if (diff[PROD_W] != diff[PROD_W-1]) begin
            sat = diff[PROD_W] ? {1'b1, {(PROD_W-1){1'b0}}} : {1'b0, {(PROD_W-1){1'b1}}};
        end else begin
            sat = diff[PROD_W-1:0];
        end
    end

    // Q15 coefficients
    assign scaled = sat >>> (COEF_W - 1);

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            y_o <= '0;
        end else begin
            y_o <= scaled[COEF_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_pdh_core -Mdir obj_dir -f all.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pdh_core)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

/* tests/tb_pdh_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pdh_core;

    localparam int CLK_PERIOD        = 40;
    localparam int DRIVE_DELAY       = 2;
    localparam int RESET_CYCLES      = 5;
    localparam int SYNC_STAGES       = 3;
    localparam int STROBE_LOW_CYCLES = SYNC_STAGES + 2;   // Low level must clear the sync chain
    localparam int CMD_WAIT_CYCLES   = 10;
    localparam int CMD_CYCLES        = 1 + STROBE_LOW_CYCLES + CMD_WAIT_CYCLES;
    localparam int DAC_SAMPLES       = 4;
    localparam int WAIT_LIMIT        = 20;
    localparam int READY_GAP         = SYNC_STAGES + 3;

    // Cycle budget of each test
    localparam int RESET_TEST_CYCLES = RESET_CYCLES + 1 + 2 * CMD_CYCLES + (DAC_SAMPLES + 1);
    localparam int LED_TEST_CYCLES   = CMD_CYCLES;
    localparam int DAC_TEST_CYCLES   = 2 * CMD_CYCLES + (DAC_SAMPLES + 1);
    localparam int ADC_TEST_CYCLES   = 1 + 3 * CMD_CYCLES;
    localparam int ROT_TEST_CYCLES   = 5 * CMD_CYCLES;
    localparam int DMA_TEST_CYCLES   = 1 + CMD_CYCLES + 2 * READY_GAP + 3 * WAIT_LIMIT;
    localparam int WATCHDOG_CYCLES   = RESET_TEST_CYCLES + LED_TEST_CYCLES + DAC_TEST_CYCLES
                                     + ADC_TEST_CYCLES + ROT_TEST_CYCLES + DMA_TEST_CYCLES + 20;

    localparam logic [3:0] CMD_SET_LED           = 4'd1;
    localparam logic [3:0] CMD_SET_DAC           = 4'd2;
    localparam logic [3:0] CMD_GET_ADC           = 4'd3;
    localparam logic [3:0] CMD_CHECK_SIGNED      = 4'd4;
    localparam logic [3:0] CMD_SET_ROT_COEFFS    = 4'd5;
    localparam logic [3:0] CMD_COMMIT_ROT_COEFFS = 4'd6;
    localparam logic [3:0] CMD_GET_FRAME         = 4'd7;

    logic        clk;
    logic        rst_i;
    logic [13:0] adc_dat_a_i;
    logic [13:0] adc_dat_b_i;
    logic [31:0] axi_from_ps_i;
    logic        dma_ready_i;
    logic        bram_ready_i;
    wire         adc_csn_o;
    wire  [13:0] dac_dat_o;
    wire         dac_wrt_o;
    wire         dac_rst_o;
    wire         dac_sel_o;
    wire  [31:0] axi_to_ps_o;
    wire  [7:0]  led_o;
    wire         dma_enable_o;
    wire         bram_enable_o;
    wire  [21:0] dma_decimation_code_o;
    wire  [63:0] dma_data_o;

    integer             seed;
    logic [13:0]        adc_a;
    logic [13:0]        adc_b;
    logic signed [15:0] a_exp;   // Held samples, shared by later tests
    logic signed [15:0] b_exp;

    pdh_core #(.SYNC_STAGES(SYNC_STAGES)) pdh_core_inst (
        .clk(clk), .rst_i(rst_i),
        .adc_dat_a_i(adc_dat_a_i), .adc_dat_b_i(adc_dat_b_i), .adc_csn_o(adc_csn_o),
        .dac_dat_o(dac_dat_o), .dac_wrt_o(dac_wrt_o), .dac_rst_o(dac_rst_o),
        .dac_sel_o(dac_sel_o), .axi_from_ps_i(axi_from_ps_i), .axi_to_ps_o(axi_to_ps_o),
        .led_o(led_o), .dma_enable_o(dma_enable_o), .bram_enable_o(bram_enable_o),
        .dma_ready_i(dma_ready_i), .bram_ready_i(bram_ready_i),
        .dma_decimation_code_o(dma_decimation_code_o), .dma_data_o(dma_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] random_word();
        random_word = $random(seed);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // Strobe low with the new word, then high, then let the callback settle
    task automatic send_cmd(input logic [3:0] cmd, input logic [25:0] data);
        next_cycle();
        axi_from_ps_i = {2'b00, cmd, data};
        repeat (STROBE_LOW_CYCLES) next_cycle();
        axi_from_ps_i = {2'b01, cmd, data};
        repeat (CMD_WAIT_CYCLES) next_cycle();
    endtask

    task automatic check_signed_readback(input logic [4:0] sel, input logic [15:0] expected,
                                         input string what);
        logic [31:0] exp_word;
        exp_word = {CMD_CHECK_SIGNED, 7'd0, sel, expected};
        send_cmd(CMD_CHECK_SIGNED, {21'd0, sel});
        check_value(64'(axi_to_ps_o), 64'(exp_word), what);
    endtask

    task automatic check_dac_outputs(input logic [13:0] exp1, input logic [13:0] exp2);
        bit seen1;
        bit seen2;
        seen1 = 1'b0;
        seen2 = 1'b0;
        repeat (DAC_SAMPLES) begin
            next_cycle();
            if (dac_sel_o) begin
                check_value(64'(dac_dat_o), 64'(exp2), "dac_dat_o channel 2");
                seen2 = 1'b1;
            end else begin
                check_value(64'(dac_dat_o), 64'(exp1), "dac_dat_o channel 1");
                seen1 = 1'b1;
            end
        end
        if (!(seen1 && seen2)) begin
            $display("dac_sel_o did not alternate between the two channels");
            stop_on_failure();
        end
        // Write strobe follows the clock
        check_value(64'(dac_wrt_o), 64'(1'b1), "dac_wrt_o while clk high");
        #(CLK_PERIOD / 2);
        check_value(64'(dac_wrt_o), 64'(1'b0), "dac_wrt_o while clk low");
    endtask

    task automatic wait_for_enable(input bit use_dma, input logic level, input string what);
        int   waited;
        logic seen;
        waited = 0;
        seen = use_dma ? dma_enable_o : bram_enable_o;
        while (seen !== level) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout: %s did not reach %0b within %0d cycles",
                         what, level, WAIT_LIMIT);
                stop_on_failure();
            end else begin
                next_cycle();
                waited++;
                seen = use_dma ? dma_enable_o : bram_enable_o;
            end
        end
    endtask

    // Saturate to 32 bits then drop the Q15 fraction
    function automatic logic [15:0] sat_scale(input longint v);
        longint s;
        s = v;
        if (s > 64'sd2147483647) s = 64'sd2147483647;
        if (s < -64'sd2147483648) s = -64'sd2147483648;
        s = s >>> 15;
        return s[15:0];
    endfunction

    ////////////////////////////////////////
    // Tests
    task automatic check_reset_values();
        check_value(64'(dac_rst_o), 64'(1'b1), "dac_rst_o during reset");
        check_value(64'(dac_sel_o), 64'(1'b0), "dac_sel_o during reset");
        check_value(64'(axi_to_ps_o), 64'd0, "callback during reset");
        check_value(64'(led_o), 64'd0, "led_o during reset");
        rst_i = 1'b0;
        next_cycle();
        check_value(64'(dac_rst_o), 64'(1'b0), "dac_rst_o after reset");
        check_value(64'(adc_csn_o), 64'(1'b1), "adc_csn_o");
        check_signed_readback(5'd2, 16'h7FFF, "cos_stage after reset");
        check_signed_readback(5'd4, 16'h7FFF, "cos_rot after reset");
        check_dac_outputs(14'h2000, 14'h2000);
        check_value(64'(dma_enable_o), 64'(1'b0), "dma_enable_o after reset");
        check_value(64'(bram_enable_o), 64'(1'b0), "bram_enable_o after reset");
    endtask

    task automatic led_write();
        logic [31:0] r;
        logic [25:0] data;
        r = random_word();
        data = r[25:0];
        send_cmd(CMD_SET_LED, data);
        check_value(64'(led_o), 64'(data[7:0]), "led_o");
        check_value(64'(axi_to_ps_o), 64'({CMD_SET_LED, 20'd0, data[7:0]}), "SET_LED callback");
    endtask

    task automatic dac_write();
        logic [31:0] r;
        logic [13:0] v1;
        logic [13:0] v2;
        r = random_word();
        v1 = r[13:0];
        v2 = r[29:16];
        send_cmd(CMD_SET_DAC, {11'd0, 1'b0, v1});
        send_cmd(CMD_SET_DAC, {11'd0, 1'b1, v2});
        check_value(64'(axi_to_ps_o), 64'({CMD_SET_DAC, v1, v2}), "SET_DAC callback");
        check_dac_outputs(v1, v2);
    endtask

    task automatic adc_readback();
        logic [31:0] r;
        r = random_word();
        next_cycle();
        adc_a = r[13:0];
        adc_b = r[29:16];
        adc_dat_a_i = adc_a;
        adc_dat_b_i = adc_b;
        a_exp = 16'd8192 - {2'b00, adc_a};
        b_exp = 16'd8192 - {2'b00, adc_b};
        send_cmd(CMD_GET_ADC, 26'd0);
        check_value(64'(axi_to_ps_o), 64'({CMD_GET_ADC, adc_b, adc_a}), "GET_ADC callback");
        check_signed_readback(5'd0, a_exp, "signed sample a");
        check_signed_readback(5'd1, b_exp, "signed sample b");
    endtask

    task automatic rotation_commit();
        logic [31:0]        r;
        logic signed [15:0] cos_v;
        logic signed [15:0] sin_v;
        logic signed [15:0] i_exp;
        logic signed [15:0] q_exp;
        r = random_word();
        cos_v = r[15:0];
        sin_v = r[31:16];
        send_cmd(CMD_SET_ROT_COEFFS, {9'd0, 1'b0, cos_v});
        send_cmd(CMD_SET_ROT_COEFFS, {9'd0, 1'b1, sin_v});
        check_value(64'(axi_to_ps_o), 64'({CMD_SET_ROT_COEFFS, sin_v[15:2], cos_v[15:2]}),
                    "SET_ROT_COEFFS callback");
        // I = cos*a - sin*b, Q = sin*a + cos*b
        i_exp = sat_scale(longint'(cos_v) * longint'(a_exp) - longint'(sin_v) * longint'(b_exp));
        q_exp = sat_scale(longint'(sin_v) * longint'(a_exp) + longint'(cos_v) * longint'(b_exp));
        send_cmd(CMD_COMMIT_ROT_COEFFS, 26'd0);
        check_value(64'(axi_to_ps_o), 64'({CMD_COMMIT_ROT_COEFFS, q_exp[15:2], i_exp[15:2]}),
                    "COMMIT_ROT_COEFFS callback");
        check_value(dma_data_o, {i_exp, q_exp, cos_v, sin_v}, "dma_data_o frame");
        check_signed_readback(5'd6, i_exp, "I readback");
        check_signed_readback(5'd7, q_exp, "Q readback");
    endtask

    task automatic dma_capture();
        logic [31:0] r;
        logic [21:0] dec;
        r = random_word();
        dec = r[21:0];
        next_cycle();
        bram_ready_i = 1'b1;
        send_cmd(CMD_GET_FRAME, {4'd0, dec});
        wait_for_enable(1'b0, 1'b1, "bram_enable_o");
        check_value(64'(dma_enable_o), 64'(1'b0), "dma_enable_o during BRAM run");
        // BRAM ready edge with DMA ready already up
        dma_ready_i = 1'b1;
        bram_ready_i = 1'b0;
        repeat (READY_GAP) next_cycle();
        check_value(64'(dma_enable_o), 64'(1'b0), "dma_enable_o before BRAM ready edge");
        bram_ready_i = 1'b1;
        wait_for_enable(1'b1, 1'b1, "dma_enable_o");
        check_value(64'(bram_enable_o), 64'(1'b0), "bram_enable_o during AXI run");
        dma_ready_i = 1'b0;
        repeat (READY_GAP) next_cycle();
        check_value(64'(dma_enable_o), 64'(1'b1), "dma_enable_o before DMA ready edge");
        dma_ready_i = 1'b1;
        wait_for_enable(1'b1, 1'b0, "dma_enable_o release");
        check_value(64'(dma_decimation_code_o), 64'(dec), "dma_decimation_code_o");
        check_value(64'(axi_to_ps_o), 64'({CMD_GET_FRAME, 5'd0, dec, 1'b1}), "GET_FRAME callback");
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        seed = 32'h9786;
        clk = 1'b0;
        rst_i = 1'b1;
        adc_dat_a_i = 14'h2000;
        adc_dat_b_i = 14'h2000;
        axi_from_ps_i = 32'd0;
        dma_ready_i = 1'b0;
        bram_ready_i = 1'b0;
        adc_a = 14'h2000;
        adc_b = 14'h2000;
        a_exp = 16'sd0;
        b_exp = 16'sd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        check_reset_values();
        led_write();
        dac_write();
        adc_readback();
        rotation_commit();
        dma_capture();
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        stop_on_failure();
    end

endmodule

`default_nettype wire
